/* hdl/cpuPkg.sv */
package cpuPkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam string PROG_FILE = "prog.hex";

    // RV32I major opcodes in the subset
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpT;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1Val;
        logic [XLEN-1:0] rs2Val;
        logic [XLEN-1:0] imm;
        aluOpT           aluOp;
        logic            useImm;
        logic            memRead;
        logic            memWrite;
        logic            regWrite;
        logic            isBranch;
        logic            branchNe;
        logic [4:0]      rd;
    } idExT;

    typedef struct packed {
        logic            valid;
        logic            branchTaken;
        logic [XLEN-1:0] branchTarget;
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] storeData;
        logic            memRead;
        logic            memWrite;
        logic            regWrite;
        logic [4:0]      rd;
    } exMemT;

    typedef struct packed {
        logic            valid;
        logic            regWrite;
        logic [4:0]      rd;
        logic [XLEN-1:0] writeData;
    } memWbT;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retireT;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } storeT;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirectT;

endpackage

/* hdl/fetchStage.sv */
module fetchStage
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     clr,
    input  redirectT redirect,
    output ifIdT     ifId
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] instr;

    initial begin
        $readmemh(PROG_FILE, imem);
    end

    // word index, upper PC bits ignored
    assign instr = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            pc <= '0;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else begin
            pc <= pc + XLEN'(4);
        end
    end

    // IF/ID, the instruction fetched under a redirect is dropped
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            ifId <= '0;
        end else begin
            ifId.valid <= !redirect.taken;
            ifId.pc    <= pc;
            ifId.instr <= instr;
        end
    end

    // branch targets come from execute, so misalignment would show up here
    pcAligned: assert property (@(posedge clk) disable iff (clr) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

/* hdl/regFile.sv */
module regFile
    import cpuPkg::*;
(
    input  logic            clk,
    input  logic            clr,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    output logic [XLEN-1:0] rs1Data,
    output logic [XLEN-1:0] rs2Data,
    input  memWbT           wb
);

    logic [XLEN-1:0] regs [32];
    logic            wrEn;

    // x0 is never written and keeps its reset zero
    assign wrEn = wb.valid && wb.regWrite && (wb.rd != 5'd0);

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rd] <= wb.writeData;
        end
    end

    // write-through bypass lets a reader three behind the producer see the new value
    function automatic logic [XLEN-1:0] readPort(input logic [4:0] addr);
        if (wrEn && (wb.rd == addr)) begin
            return wb.writeData;
        end
        return regs[addr];
    endfunction

    assign rs1Data = readPort(rs1Addr);
    assign rs2Data = readPort(rs2Addr);

    x0Zero: assert property (@(posedge clk) disable iff (clr)
        ((rs1Addr == 5'd0) -> (rs1Data == '0)) && ((rs2Addr == 5'd0) -> (rs2Data == '0)))
        else $error("register 0 read nonzero");

endmodule

/* hdl/decodeStage.sv */
module decodeStage
    import cpuPkg::*;
(
    input  logic            clk,
    input  logic            clr,
    input  ifIdT            ifId,
    input  logic            flush,
    output logic [4:0]      rs1Addr,
    output logic [4:0]      rs2Addr,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    output idExT            idEx
);

    logic [XLEN-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    idExT            idExNext;

    assign instr   = ifId.instr;
    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // anything not matched below leaves all write enables low
    always_comb begin
        idExNext        = '0;
        idExNext.valid  = ifId.valid && !flush;
        idExNext.pc     = ifId.pc;
        idExNext.rs1Val = rs1Data;
        idExNext.rs2Val = rs2Data;
        idExNext.rd     = instr[11:7];
        idExNext.aluOp  = ALU_ADD;
        case (opcode)
            OPC_REG: begin
                idExNext.regWrite = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: idExNext.aluOp = ALU_ADD;
                    {7'h20, 3'b000}: idExNext.aluOp = ALU_SUB;
                    {7'h00, 3'b111}: idExNext.aluOp = ALU_AND;
                    {7'h00, 3'b110}: idExNext.aluOp = ALU_OR;
                    {7'h00, 3'b100}: idExNext.aluOp = ALU_XOR;
                    {7'h00, 3'b010}: idExNext.aluOp = ALU_SLT;
                    default:         idExNext.regWrite = 1'b0;
                endcase
            end
            OPC_IMM: begin
                if (funct3 == 3'b000) begin
                    idExNext.useImm   = 1'b1;
                    idExNext.regWrite = 1'b1;
                    idExNext.imm      = immI;
                end
            end
            OPC_LOAD: begin
                // word loads only
                if (funct3 == 3'b010) begin
                    idExNext.useImm   = 1'b1;
                    idExNext.memRead  = 1'b1;
                    idExNext.regWrite = 1'b1;
                    idExNext.imm      = immI;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    idExNext.useImm   = 1'b1;
                    idExNext.memWrite = 1'b1;
                    idExNext.imm      = immS;
                end
            end
            OPC_BRANCH: begin
                // beq is 000, bne is 001
                if (funct3[2:1] == 2'b00) begin
                    idExNext.isBranch = 1'b1;
                    idExNext.branchNe = funct3[0];
                    idExNext.imm      = immB;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

/* hdl/executeStage.sv */
module executeStage
    import cpuPkg::*;
(
    input  logic  clk,
    input  logic  clr,
    input  idExT  idEx,
    input  logic  flush,
    output exMemT exMem
);

    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;
    logic            operandsEqual;
    exMemT           exMemNext;

    assign opB = idEx.useImm ? idEx.imm : idEx.rs2Val;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluResult = idEx.rs1Val + opB;
            ALU_SUB: aluResult = idEx.rs1Val - opB;
            ALU_AND: aluResult = idEx.rs1Val & opB;
            ALU_OR:  aluResult = idEx.rs1Val | opB;
            ALU_XOR: aluResult = idEx.rs1Val ^ opB;
            ALU_SLT: aluResult = XLEN'($signed(idEx.rs1Val) < $signed(opB));
            default: aluResult = '0;
        endcase
    end

    // branch compare always uses rs2, never the immediate
    assign operandsEqual = (idEx.rs1Val == idEx.rs2Val);

    always_comb begin
        exMemNext              = '0;
        exMemNext.valid        = idEx.valid && !flush;
        exMemNext.branchTaken  = idEx.isBranch && (operandsEqual ^ idEx.branchNe);
        exMemNext.branchTarget = idEx.pc + idEx.imm;
        exMemNext.aluResult    = aluResult;
        exMemNext.storeData    = idEx.rs2Val;
        exMemNext.memRead      = idEx.memRead;
        exMemNext.memWrite     = idEx.memWrite;
        exMemNext.regWrite     = idEx.regWrite;
        exMemNext.rd           = idEx.rd;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            exMem <= '0;
        end else begin
            exMem <= exMemNext;
        end
    end

    // decode must never let a branch write back its rd field
    branchNoWrite: assert property (@(posedge clk) disable iff (clr)
        (idEx.valid && idEx.isBranch) |-> !idEx.regWrite)
        else $error("branch with regWrite set at pc %h", idEx.pc);

endmodule

/* hdl/memoryStage.sv */
module memoryStage
    import cpuPkg::*;
(
    input  logic     clk,
    input  logic     clr,
    input  exMemT    exMem,
    output redirectT redirect,
    output storeT    store,
    output memWbT    memWb
);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] wordAddr;
    logic [XLEN-1:0]    loadData;
    logic               storeEn;

    assign wordAddr = exMem.aluResult[DMEM_AW+1:2];
    assign loadData = dmem[wordAddr];
    assign storeEn  = exMem.valid && exMem.memWrite;

    always_ff @(posedge clk) begin
        if (storeEn) begin
            dmem[wordAddr] <= exMem.storeData;
        end
    end

    // branch resolves here and flushes the three younger slots
    assign redirect.taken  = exMem.valid && exMem.branchTaken;
    assign redirect.target = exMem.branchTarget;

    assign store.valid = storeEn;
    assign store.addr  = exMem.aluResult;
    assign store.data  = exMem.storeData;

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            memWb <= '0;
        end else begin
            memWb.valid     <= exMem.valid;
            memWb.regWrite  <= exMem.regWrite;
            memWb.rd        <= exMem.rd;
            memWb.writeData <= exMem.memRead ? loadData : exMem.aluResult;
        end
    end

endmodule

/* hdl/cpuPipe.sv */
module cpuPipe
    import cpuPkg::*;
(
    input  logic   clk,
    input  logic   clr,
    output retireT retire,
    output storeT  store
);

    ifIdT            ifId;
    idExT            idEx;
    exMemT           exMem;
    memWbT           memWb;
    redirectT        redirect;
    logic [4:0]      rs1Addr;
    logic [4:0]      rs2Addr;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;

    fetchStage fetchStage_inst (
        .clk      (clk),
        .clr      (clr),
        .redirect (redirect),
        .ifId     (ifId)
    );

    regFile regFile_inst (
        .clk     (clk),
        .clr     (clr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (memWb)
    );

    decodeStage decodeStage_inst (
        .clk     (clk),
        .clr     (clr),
        .ifId    (ifId),
        .flush   (redirect.taken),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .idEx    (idEx)
    );

    executeStage executeStage_inst (
        .clk   (clk),
        .clr   (clr),
        .idEx  (idEx),
        .flush (redirect.taken),
        .exMem (exMem)
    );

    memoryStage memoryStage_inst (
        .clk      (clk),
        .clr      (clr),
        .exMem    (exMem),
        .redirect (redirect),
        .store    (store),
        .memWb    (memWb)
    );

    // same qualification as the register file write port
    assign retire.valid = memWb.valid && memWb.regWrite && (memWb.rd != 5'd0);
    assign retire.rd    = memWb.rd;
    assign retire.data  = memWb.writeData;

endmodule

/* tb/cpuPipeTb.sv */
module cpuPipeTb
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_WORDS   = 32;
    localparam int DRAIN_CYCLES = 8;
    // straight-line length, branch bubbles and pipeline fill, with a wide margin
    localparam int CYCLE_LIMIT  = 6 * PROG_WORDS + DRAIN_CYCLES;
    localparam int RET_COUNT    = 15;
    localparam int ST_COUNT     = 2;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retireEntryT;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } storeEntryT;

    // program order, the x0 write and the six skipped addi never show up
    localparam retireEntryT RET_TABLE [RET_COUNT] = '{
        {5'd1,  32'd5},
        {5'd2,  32'hffff_fffd},
        {5'd3,  32'd12},
        // 5 + -3, x2 only three slots back
        {5'd4,  32'd2},
        {5'd5,  32'd8},
        {5'd6,  32'd4},
        {5'd7,  32'd13},
        {5'd8,  32'd9},
        // -3 < 5 signed
        {5'd9,  32'd1},
        {5'd10, 32'd0},
        // x0 + x4
        {5'd11, 32'd2},
        // lw of the word stored at 20
        {5'd12, 32'd8},
        {5'd13, 32'd7},
        {5'd14, 32'd9},
        {5'd15, 32'd15}
    };

    // x3 = 12 as base, sw x5 at +8 then sw x13 at +4
    localparam storeEntryT ST_TABLE [ST_COUNT] = '{
        {32'd20, 32'd8},
        {32'd16, 32'd7}
    };

    logic   clk;
    logic   clr;
    retireT retire;
    storeT  store;
    int     retIdx;
    int     stIdx;
    int     cycleCount;
    int     quietCycles;

    cpuPipe cpuPipe_inst (
        .clk    (clk),
        .clr    (clr),
        .retire (retire),
        .store  (store)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk or posedge clr) begin
        if (clr) begin
            retIdx <= 0;
            stIdx  <= 0;
        end else begin
            if (retire.valid) begin
                retIdx <= retIdx + 1;
            end
            if (store.valid) begin
                stIdx <= stIdx + 1;
            end
        end
    end

    // quiet time after the last expected report catches stray retires
    always @(posedge clk or posedge clr) begin
        if (clr) begin
            cycleCount  <= 0;
            quietCycles <= 0;
        end else begin
            cycleCount <= cycleCount + 1;
            if (retIdx == RET_COUNT && stIdx == ST_COUNT) begin
                quietCycles <= quietCycles + 1;
            end
        end
    end

    retireOrder: assert property (@(posedge clk) disable iff (clr)
        (retire.valid && retIdx < RET_COUNT) |->
            (retire.rd == RET_TABLE[retIdx].rd && retire.data == RET_TABLE[retIdx].data))
        else failRun($sformatf("FAIL %0t: retire %0d expected x%0d = %h, got x%0d = %h",
            $time, $sampled(retIdx), RET_TABLE[$sampled(retIdx)].rd,
            RET_TABLE[$sampled(retIdx)].data, $sampled(retire.rd), $sampled(retire.data)));

    retireCount: assert property (@(posedge clk) disable iff (clr)
        retire.valid |-> (retIdx < RET_COUNT))
        else failRun("a retire report arrived after the last expected one");

    storeOrder: assert property (@(posedge clk) disable iff (clr)
        (store.valid && stIdx < ST_COUNT) |->
            (store.addr == ST_TABLE[stIdx].addr && store.data == ST_TABLE[stIdx].data))
        else failRun($sformatf("FAIL %0t: store %0d expected [%h] = %h, got [%h] = %h",
            $time, $sampled(stIdx), ST_TABLE[$sampled(stIdx)].addr,
            ST_TABLE[$sampled(stIdx)].data, $sampled(store.addr), $sampled(store.data)));

    storeCount: assert property (@(posedge clk) disable iff (clr)
        store.valid |-> (stIdx < ST_COUNT))
        else failRun("a store report arrived after the last expected one");

    initial begin
        clk = 1'b0;
        clr = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        clr = 1'b0;
        while (quietCycles < DRAIN_CYCLES && cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
            #1;
        end
        if (quietCycles >= DRAIN_CYCLES) begin
            $display("All checks passed");
            $finish;
        end else begin
            failRun($sformatf("timeout, the program did not finish within %0d cycles",
                CYCLE_LIMIT));
        end
    end

endmodule

/* tb/prog.hex */
// instruction word in hex, one per line from address 0, assembly after it
// the taken branch at 14 skips 15..17, the one at 18 skips 19..21
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
03700013 // addi x0, x0, 55
00c00193 // addi x3, x0, 12
00208233 // add  x4, x1, x2
402082b3 // sub  x5, x1, x2
0030f333 // and  x6, x1, x3
0030e3b3 // or   x7, x1, x3
0030c433 // xor  x8, x1, x3
001124b3 // slt  x9, x2, x1
0020a533 // slt  x10, x1, x2
004005b3 // add  x11, x0, x4
0051a423 // sw   x5, 8(x3)
0081a603 // lw   x12, 8(x3)
00108863 // beq  x1, x1, +16
00100693 // addi x13, x0, 1
00200693 // addi x13, x0, 2
00300693 // addi x13, x0, 3
00209863 // bne  x1, x2, +16
00100713 // addi x14, x0, 1
00200713 // addi x14, x0, 2
00300713 // addi x14, x0, 3
00208463 // beq  x1, x2, +8
00700693 // addi x13, x0, 7
00109463 // bne  x1, x1, +8
00900713 // addi x14, x0, 9
00d607b3 // add  x15, x12, x13
00d1a223 // sw   x13, 4(x3)
00000063 // beq  x0, x0, 0
00000013 // nop
00000013 // nop
00000013 // nop

/* sources.f */
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuPipe.sv
tb/cpuPipeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuPipeTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
# fetch reads prog.hex from the working directory
SIM_DIR   ?= tb

SIM_BIN = $(abspath $(OBJ_DIR))/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	cd $(SIM_DIR) && $(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
